/* tb.f */
+incdir+tb
verilog/agen_pkg.sv
verilog/reg_size_select.sv
verilog/string_address.sv
verilog/operand_select.sv
verilog/agen_pipestage.sv
verilog/address_generation_top.sv
tb/tb_agen.sv

/* run_sim.sh */
#!/bin/sh
# compile tb_agen with Verilator from tb.f, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_agen -o tb_agen \
    > build.log 2>&1 \
    || { cat build.log; echo "BUILD ERROR"; exit 1; }

./obj_dir/tb_agen > sim.log 2>&1
cat sim.log

grep -qx "All checks passed" sim.log \
    && { echo "SIMULATION PASSED"; exit 0; } \
    || { echo "SIMULATION FAILED"; exit 1; }

/* tb/agen_model.svh */
// --------------------
// expected stage outputs built from the operand, address and flag rules
// included inside tb_agen, after the agen_pkg import
// --------------------
`ifndef AGEN_MODEL_SVH
`define AGEN_MODEL_SVH

typedef struct packed {
    size_t       size;
    operand_t    op0;
    operand_t    op1;
    reg_idx_t    op0_reg;
    reg_idx_t    op1_reg;
    logic        op0_is_address;
    logic        op0_is_reg;
    logic        op0_is_segment;
    logic        op1_is_reg;
    logic        op1_is_address;
    imm_t        imm;
    logic [1:0]  stack_op;
    lin_addr_t   stack_address;
    lin_addr_t   pc;
    logic [15:0] opcode;
    logic        to_sys_controller;
} expect_t;

// regs holds eax..edi at 0..7
function automatic gpr_t model_reg_view(size_t size, reg_idx_t idx, gpr_t [7:0] regs);
    if (size == SIZE_8) begin
        // upper four indices are ah, ch, dh, bh
        if (idx[2])
            return {24'd0, regs[{1'b0, idx[1:0]}][15:8]};
        return {24'd0, regs[idx][7:0]};
    end
    if (size == SIZE_16)
        return {16'd0, regs[idx][15:0]};
    if (size == SIZE_32)
        return regs[idx];
    return '0;
endfunction

// segs holds es, cs, ss, ds, fs, gs at 0..5
function automatic seg_t model_seg(seg_idx_t idx, seg_t [5:0] segs);
    if (idx > SEG_GS)
        return '0;
    return segs[idx];
endfunction

// selector times 2^SEG_SHIFT plus offset, wraps at 32 bits
function automatic lin_addr_t model_linear(seg_t sel, gpr_t offset);
    return 32'(sel) * (32'd1 << SEG_SHIFT) + offset;
endfunction

function automatic operand_t model_operand(op_kind_t kind, gpr_t view, seg_t seg,
                                           imm_t imm, lin_addr_t addr);
    case (kind)
        KIND_REG: return 64'(view);
        KIND_SEG: return 64'(seg);
        KIND_IMM: return 64'(imm);
        KIND_MEM: return 64'(addr);
        default:  return '0;
    endcase
endfunction

`endif

/* tb/tb_agen.sv */
// --------------------
// random items under random a_ready back-pressure
// random flushes plus one reset in mid-run
// --------------------
`timescale 1ns/10ps

module tb_agen import agen_pkg::*; ();

    localparam int NUM_CYCLES  = 3000;
    localparam int RESET_AT    = 1500;
    localparam int DRAIN_LIMIT = 20;

    `include "agen_model.svh"

    logic        clk;
    logic        rst;
    logic        flush;
    logic        r_valid;
    logic        r_ready;
    size_t       r_size;
    op_kind_t    r_op0, r_op1;
    reg_idx_t    r_op0_reg, r_op1_reg;
    imm_t        r_imm;
    logic [1:0]  r_stack_op;
    lin_addr_t   r_stack_address, r_pc;
    seg_idx_t    r_seg_override;
    logic        r_seg_override_valid;
    gpr_t        r_eax, r_ecx, r_edx, r_ebx, r_esp, r_ebp, r_esi, r_edi;
    seg_t        r_cs, r_ds, r_es, r_fs, r_gs, r_ss;
    logic [15:0] r_opcode;
    logic        a_valid;
    logic        a_ready;
    size_t       a_size;
    operand_t    a_op0, a_op1;
    reg_idx_t    a_op0_reg, a_op1_reg;
    logic        a_op0_is_address, a_op0_is_reg, a_op0_is_segment;
    logic        a_op1_is_reg, a_op1_is_address;
    imm_t        a_imm;
    logic [1:0]  a_stack_op;
    lin_addr_t   a_stack_address, a_pc;
    logic [15:0] a_opcode;
    logic        a_to_sys_controller;

    int          seed = 32'h4892;
    int          error_count = 0;
    int          checked = 0;
    int          drain_wait;
    logic        hold_input;
    logic        expect_idle;
    logic        expect_stable;
    logic        expect_valid;
    expect_t     held;
    expect_t     exp_q[$];

    address_generation_top i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic expect_t predict();
        expect_t    e;
        gpr_t [7:0] regs;
        seg_t [5:0] segs;
        seg_t       src_seg;
        regs = {r_edi, r_esi, r_ebp, r_esp, r_ebx, r_edx, r_ecx, r_eax};
        segs = {r_gs, r_fs, r_ds, r_ss, r_cs, r_es};
        src_seg = r_seg_override_valid ? model_seg(r_seg_override, segs) : r_ds;
        e.size = r_size;
        e.op0 = model_operand(r_op0, model_reg_view(r_size, r_op0_reg, regs),
                              model_seg(r_op0_reg, segs), r_imm, model_linear(r_es, r_edi));
        e.op1 = model_operand(r_op1, model_reg_view(r_size, r_op1_reg, regs),
                              model_seg(r_op1_reg, segs), r_imm, model_linear(src_seg, r_esi));
        // pop takes the stack slot
        if (r_stack_op[1])
            e.op1 = 64'(r_stack_address);
        e.op0_reg = r_op0_reg;
        e.op1_reg = r_op1_reg;
        e.op0_is_address = (r_op0 == KIND_MEM);
        e.op0_is_reg = (r_op0 == KIND_REG);
        e.op0_is_segment = (r_op0 == KIND_SEG);
        e.op1_is_reg = (r_op1 == KIND_REG);
        e.op1_is_address = (r_op1 == KIND_MEM) || r_stack_op[1];
        e.imm = r_imm;
        e.stack_op = r_stack_op;
        e.stack_address = r_stack_address;
        e.pc = r_pc;
        e.opcode = r_opcode;
        e.to_sys_controller = (r_op0 == KIND_SYS);
        return e;
    endfunction

    function automatic expect_t observed();
        return {a_size, a_op0, a_op1, a_op0_reg, a_op1_reg, a_op0_is_address,
                a_op0_is_reg, a_op0_is_segment, a_op1_is_reg, a_op1_is_address,
                a_imm, a_stack_op, a_stack_address, a_pc, a_opcode, a_to_sys_controller};
    endfunction

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            error_count++;
            $display("Mismatch at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_item(input expect_t e);
        compare_field("a_size", 64'(a_size), 64'(e.size));
        compare_field("a_op0", a_op0, e.op0);
        compare_field("a_op1", a_op1, e.op1);
        compare_field("a_op0_reg", 64'(a_op0_reg), 64'(e.op0_reg));
        compare_field("a_op1_reg", 64'(a_op1_reg), 64'(e.op1_reg));
        compare_field("a_op0_is_address", 64'(a_op0_is_address), 64'(e.op0_is_address));
        compare_field("a_op0_is_reg", 64'(a_op0_is_reg), 64'(e.op0_is_reg));
        compare_field("a_op0_is_segment", 64'(a_op0_is_segment), 64'(e.op0_is_segment));
        compare_field("a_op1_is_reg", 64'(a_op1_is_reg), 64'(e.op1_is_reg));
        compare_field("a_op1_is_address", 64'(a_op1_is_address), 64'(e.op1_is_address));
        compare_field("a_imm", 64'(a_imm), 64'(e.imm));
        compare_field("a_stack_op", 64'(a_stack_op), 64'(e.stack_op));
        compare_field("a_stack_address", 64'(a_stack_address), 64'(e.stack_address));
        compare_field("a_pc", 64'(a_pc), 64'(e.pc));
        compare_field("a_opcode", 64'(a_opcode), 64'(e.opcode));
        compare_field("a_to_sys_controller", 64'(a_to_sys_controller),
                      64'(e.to_sys_controller));
    endtask

    // every code field uniform over its full range
    task automatic randomize_item();
        logic [31:0] w;
        w = rand_word();
        r_size = w[2:0];
        r_op0 = w[5:3];
        r_op1 = w[8:6];
        r_op0_reg = w[11:9];
        r_op1_reg = w[14:12];
        r_stack_op = w[16:15];
        r_seg_override = w[19:17];
        r_seg_override_valid = w[20];
        r_opcode = w[31:16];
        w = rand_word();
        r_imm = {w[15:0], rand_word()};
        r_eax = rand_word();
        r_ecx = rand_word();
        r_edx = rand_word();
        r_ebx = rand_word();
        r_esp = rand_word();
        r_ebp = rand_word();
        r_esi = rand_word();
        r_edi = rand_word();
        w = rand_word();
        r_cs = w[15:0];
        r_ds = w[31:16];
        w = rand_word();
        r_es = w[15:0];
        r_fs = w[31:16];
        w = rand_word();
        r_gs = w[15:0];
        r_ss = w[31:16];
        r_stack_address = rand_word();
        r_pc = rand_word();
    endtask

    task automatic drive_cycle(input int cycle);
        logic [31:0] w;
        w = rand_word();
        rst = (cycle == RESET_AT) || (cycle == RESET_AT + 1);
        // flush about 3%, a_ready low about 30%
        flush = !rst && (w[4:0] == 5'd0);
        a_ready = !rst && (w[15:8] >= 8'd77);
        // a refused item stays on the inputs
        if (!hold_input) begin
            r_valid = (w[23:16] >= 8'd64);
            randomize_item();
        end
        if (rst)
            r_valid = 1'b0;
    endtask

    // runs between the falling and the next rising edge
    task automatic sample_cycle();
        logic ready_exp;
        // room when empty or draining, never during flush
        ready_exp = !flush && (!a_valid || a_ready);
        compare_field("r_ready", 64'(r_ready), 64'(ready_exp));
        if (expect_idle) begin
            assert (!a_valid) else begin
                error_count++;
                $display("a_valid is high the cycle after a flush or reset, at %0d ns", $time);
            end
        end
        if (expect_valid) begin
            assert (a_valid) else begin
                error_count++;
                $display("a_valid is low the cycle after an item was accepted, at %0d ns",
                         $time);
            end
        end
        if (expect_stable) begin
            assert (a_valid && observed() == held) else begin
                error_count++;
                $display("held output changed while a_ready was low, at %0d ns", $time);
            end
        end
        if (a_valid && a_ready) begin
            assert (exp_q.size() > 0) else begin
                error_count++;
                $display("output item at %0d ns with no accepted item pending", $time);
            end
            if (exp_q.size() > 0) begin
                check_item(exp_q.pop_front());
                checked++;
            end
        end
        if (r_valid && r_ready)
            exp_q.push_back(predict());
        expect_valid = r_valid && r_ready && !rst;
        expect_stable = a_valid && !a_ready && !flush && !rst;
        held = observed();
        expect_idle = flush || rst;
        if (expect_idle)
            exp_q.delete();
        hold_input = r_valid && !r_ready;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        a_ready = 1'b0;
        r_valid = 1'b0;
        hold_input = 1'b0;
        expect_idle = 1'b1;
        expect_stable = 1'b0;
        expect_valid = 1'b0;
        randomize_item();
        repeat (4) @(posedge clk);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(negedge clk);
            drive_cycle(cycle);
            #1;
            sample_cycle();
        end
        // drain what is still in flight
        drain_wait = 0;
        while (exp_q.size() > 0 && drain_wait < DRAIN_LIMIT) begin
            @(negedge clk);
            r_valid = 1'b0;
            flush = 1'b0;
            a_ready = 1'b1;
            #1;
            sample_cycle();
            drain_wait++;
        end
        assert (exp_q.size() == 0) else begin
            error_count++;
            $display("timeout: %0d accepted items never reached the output", exp_q.size());
        end
        $display("%0d items checked, %0d errors", checked, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* verilog/address_generation_top.sv */
// --------------------
// string addressing only, no modrm/sib and no segment limit checks
// one cycle latency with a_ready high
// --------------------
`timescale 1ns/10ps

module address_generation_top import agen_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        r_valid,
    output logic        r_ready,
    input  size_t       r_size,
    input  op_kind_t    r_op0,
    input  op_kind_t    r_op1,
    input  reg_idx_t    r_op0_reg,
    input  reg_idx_t    r_op1_reg,
    input  imm_t        r_imm,
    input  logic [1:0]  r_stack_op,
    input  lin_addr_t   r_stack_address,
    input  seg_idx_t    r_seg_override,
    input  logic        r_seg_override_valid,
    input  gpr_t        r_eax,
    input  gpr_t        r_ecx,
    input  gpr_t        r_edx,
    input  gpr_t        r_ebx,
    input  gpr_t        r_esp,
    input  gpr_t        r_ebp,
    input  gpr_t        r_esi,
    input  gpr_t        r_edi,
    input  seg_t        r_cs,
    input  seg_t        r_ds,
    input  seg_t        r_es,
    input  seg_t        r_fs,
    input  seg_t        r_gs,
    input  seg_t        r_ss,
    input  lin_addr_t   r_pc,
    input  logic [15:0] r_opcode,
    output logic        a_valid,
    input  logic        a_ready,
    output size_t       a_size,
    output operand_t    a_op0,
    output operand_t    a_op1,
    output reg_idx_t    a_op0_reg,
    output reg_idx_t    a_op1_reg,
    output logic        a_op0_is_address,
    output logic        a_op0_is_reg,
    output logic        a_op0_is_segment,
    output logic        a_op1_is_reg,
    output logic        a_op1_is_address,
    output imm_t        a_imm,
    output logic [1:0]  a_stack_op,
    output lin_addr_t   a_stack_address,
    output lin_addr_t   a_pc,
    output logic [15:0] a_opcode,
    output logic        a_to_sys_controller
);

    gpr_t      reg_0;
    gpr_t      reg_1;
    gpr_t      reg_2;
    gpr_t      reg_3;
    gpr_t      reg_4;
    gpr_t      reg_5;
    gpr_t      reg_6;
    gpr_t      reg_7;
    lin_addr_t dest_addr;
    lin_addr_t src_addr;
    operand_t  p_op0;
    operand_t  gen_op1;
    operand_t  p_op1;
    logic      p_op0_is_address;
    logic      p_op0_is_reg;
    logic      p_op0_is_segment;
    logic      p_op1_is_reg;
    logic      gen_op1_is_address;
    logic      p_op1_is_address;
    logic      p_to_sys_controller;

    // one set of size views serves both operands
    reg_size_select u_reg_size (
        .size(r_size), .eax(r_eax), .ecx(r_ecx), .edx(r_edx), .ebx(r_ebx),
        .esp(r_esp), .ebp(r_ebp), .esi(r_esi), .edi(r_edi),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2), .reg_3(reg_3),
        .reg_4(reg_4), .reg_5(reg_5), .reg_6(reg_6), .reg_7(reg_7)
    );

    string_address u_string_addr (
        .es(r_es), .ds(r_ds), .cs(r_cs), .ss(r_ss), .fs(r_fs), .gs(r_gs),
        .edi(r_edi), .esi(r_esi),
        .seg_override(r_seg_override), .seg_override_valid(r_seg_override_valid),
        .dest_addr(dest_addr), .src_addr(src_addr)
    );

    // op0 is the destination, es:edi
    operand_select u_op0_select (
        .kind(r_op0), .reg_idx(r_op0_reg),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2), .reg_3(reg_3),
        .reg_4(reg_4), .reg_5(reg_5), .reg_6(reg_6), .reg_7(reg_7),
        .es(r_es), .cs(r_cs), .ss(r_ss), .ds(r_ds), .fs(r_fs), .gs(r_gs),
        .imm(r_imm), .mem_addr(dest_addr),
        .operand(p_op0), .is_address(p_op0_is_address),
        .is_reg(p_op0_is_reg), .is_segment(p_op0_is_segment)
    );

    // op1 is the source, ds:esi or the prefix segment
    operand_select u_op1_select (
        .kind(r_op1), .reg_idx(r_op1_reg),
        .reg_0(reg_0), .reg_1(reg_1), .reg_2(reg_2), .reg_3(reg_3),
        .reg_4(reg_4), .reg_5(reg_5), .reg_6(reg_6), .reg_7(reg_7),
        .es(r_es), .cs(r_cs), .ss(r_ss), .ds(r_ds), .fs(r_fs), .gs(r_gs),
        .imm(r_imm), .mem_addr(src_addr),
        .operand(gen_op1), .is_address(gen_op1_is_address),
        .is_reg(p_op1_is_reg), .is_segment()
    );

    // a pop reads from the stack slot whatever op1 was decoded as
    assign p_op1            = r_stack_op[1] ? operand_t'(r_stack_address) : gen_op1;
    assign p_op1_is_address = gen_op1_is_address | r_stack_op[1];

    assign p_to_sys_controller = (r_op0 == KIND_SYS);

    agen_pipestage u_pipestage (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(r_valid), .in_ready(r_ready),
        .in_size(r_size), .in_op0(p_op0), .in_op1(p_op1),
        .in_op0_reg(r_op0_reg), .in_op1_reg(r_op1_reg),
        .in_op0_is_address(p_op0_is_address), .in_op0_is_reg(p_op0_is_reg),
        .in_op0_is_segment(p_op0_is_segment), .in_op1_is_reg(p_op1_is_reg),
        .in_op1_is_address(p_op1_is_address), .in_imm(r_imm),
        .in_stack_op(r_stack_op), .in_stack_address(r_stack_address),
        .in_pc(r_pc), .in_opcode(r_opcode),
        .in_to_sys_controller(p_to_sys_controller),
        .out_valid(a_valid), .out_ready(a_ready),
        .out_size(a_size), .out_op0(a_op0), .out_op1(a_op1),
        .out_op0_reg(a_op0_reg), .out_op1_reg(a_op1_reg),
        .out_op0_is_address(a_op0_is_address), .out_op0_is_reg(a_op0_is_reg),
        .out_op0_is_segment(a_op0_is_segment), .out_op1_is_reg(a_op1_is_reg),
        .out_op1_is_address(a_op1_is_address), .out_imm(a_imm),
        .out_stack_op(a_stack_op), .out_stack_address(a_stack_address),
        .out_pc(a_pc), .out_opcode(a_opcode),
        .out_to_sys_controller(a_to_sys_controller)
    );

endmodule

/* verilog/agen_pipestage.sv */
// --------------------
// single entry output register, valid/ready on both sides
// flush drops the held item and blocks input while high
// --------------------
`timescale 1ns/10ps

module agen_pipestage import agen_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      in_valid,
    output logic      in_ready,
    input  size_t     in_size,
    input  operand_t  in_op0,
    input  operand_t  in_op1,
    input  reg_idx_t  in_op0_reg,
    input  reg_idx_t  in_op1_reg,
    input  logic      in_op0_is_address,
    input  logic      in_op0_is_reg,
    input  logic      in_op0_is_segment,
    input  logic      in_op1_is_reg,
    input  logic      in_op1_is_address,
    input  imm_t      in_imm,
    input  logic [1:0] in_stack_op,
    input  lin_addr_t in_stack_address,
    input  lin_addr_t in_pc,
    input  logic [15:0] in_opcode,
    input  logic      in_to_sys_controller,
    output logic      out_valid,
    input  logic      out_ready,
    output size_t     out_size,
    output operand_t  out_op0,
    output operand_t  out_op1,
    output reg_idx_t  out_op0_reg,
    output reg_idx_t  out_op1_reg,
    output logic      out_op0_is_address,
    output logic      out_op0_is_reg,
    output logic      out_op0_is_segment,
    output logic      out_op1_is_reg,
    output logic      out_op1_is_address,
    output imm_t      out_imm,
    output logic [1:0] out_stack_op,
    output lin_addr_t out_stack_address,
    output lin_addr_t out_pc,
    output logic [15:0] out_opcode,
    output logic      out_to_sys_controller
);

    // free slot, or the slot empties this edge
    assign in_ready = (!out_valid || out_ready) && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on a transfer, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_size              <= in_size;
            out_op0               <= in_op0;
            out_op1               <= in_op1;
            out_op0_reg           <= in_op0_reg;
            out_op1_reg           <= in_op1_reg;
            out_op0_is_address    <= in_op0_is_address;
            out_op0_is_reg        <= in_op0_is_reg;
            out_op0_is_segment    <= in_op0_is_segment;
            out_op1_is_reg        <= in_op1_is_reg;
            out_op1_is_address    <= in_op1_is_address;
            out_imm               <= in_imm;
            out_stack_op          <= in_stack_op;
            out_stack_address     <= in_stack_address;
            out_pc                <= in_pc;
            out_opcode            <= in_opcode;
            out_to_sys_controller <= in_to_sys_controller;
        end
    end

endmodule

/* verilog/operand_select.sv */
// --------------------
// combinational operand mux, one per operand slot
// kinds none, sys, 3 and 4 give a zero operand
// --------------------
`timescale 1ns/10ps

module operand_select import agen_pkg::*; (
    input  op_kind_t  kind,
    input  reg_idx_t  reg_idx,
    input  gpr_t      reg_0,
    input  gpr_t      reg_1,
    input  gpr_t      reg_2,
    input  gpr_t      reg_3,
    input  gpr_t      reg_4,
    input  gpr_t      reg_5,
    input  gpr_t      reg_6,
    input  gpr_t      reg_7,
    input  seg_t      es,
    input  seg_t      cs,
    input  seg_t      ss,
    input  seg_t      ds,
    input  seg_t      fs,
    input  seg_t      gs,
    input  imm_t      imm,
    input  lin_addr_t mem_addr,
    output operand_t  operand,
    output logic      is_address,
    output logic      is_reg,
    output logic      is_segment
);

    gpr_t reg_value;
    seg_t seg_value;

    // register view picked by the reg field
    always_comb begin
        case (reg_idx)
            3'd0:    reg_value = reg_0;
            3'd1:    reg_value = reg_1;
            3'd2:    reg_value = reg_2;
            3'd3:    reg_value = reg_3;
            3'd4:    reg_value = reg_4;
            3'd5:    reg_value = reg_5;
            3'd6:    reg_value = reg_6;
            default: reg_value = reg_7;
        endcase
    end

    // same reg field doubles as segment number
    assign seg_value = seg_pick(reg_idx, es, cs, ss, ds, fs, gs);

    always_comb begin
        case (kind)
            KIND_REG:            operand = operand_t'(reg_value);
            KIND_SEG:            operand = operand_t'(seg_value);
            KIND_IMM:            operand = operand_t'(imm);
            KIND_MEM:            operand = operand_t'(mem_addr);
            KIND_NONE, KIND_SYS: operand = '0;
            default:             operand = '0;
        endcase
    end

    // memory kind is read later in the memory stage
    assign is_address = (kind == KIND_MEM);
    assign is_reg     = (kind == KIND_REG);
    assign is_segment = (kind == KIND_SEG);

endmodule

/* verilog/string_address.sv */
// --------------------
// combinational, real mode style bases only, no limit check
// sums wrap modulo 2^32
// --------------------
`timescale 1ns/10ps

module string_address import agen_pkg::*; (
    input  seg_t      es,
    input  seg_t      ds,
    input  seg_t      cs,
    input  seg_t      ss,
    input  seg_t      fs,
    input  seg_t      gs,
    input  gpr_t      edi,
    input  gpr_t      esi,
    input  seg_idx_t  seg_override,
    input  logic      seg_override_valid,
    output lin_addr_t dest_addr,
    output lin_addr_t src_addr
);

    seg_t      override_seg;
    seg_t      src_seg;
    lin_addr_t dest_base;
    lin_addr_t src_base;

    // destination is always es, a prefix cannot move it
    assign dest_base = lin_addr_t'(es) << SEG_SHIFT;

    // source defaults to ds unless a segment prefix is present
    assign override_seg = seg_pick(seg_override, es, cs, ss, ds, fs, gs);
    assign src_seg      = seg_override_valid ? override_seg : ds;
    assign src_base     = lin_addr_t'(src_seg) << SEG_SHIFT;

    assign dest_addr = dest_base + edi;
    assign src_addr  = src_base + esi;

endmodule

/* verilog/reg_size_select.sv */
// --------------------
// purely combinational
// sizes other than 8, 16 and 32 bit give all-zero views
// --------------------
`timescale 1ns/10ps

module reg_size_select import agen_pkg::*; (
    input  size_t size,
    input  gpr_t  eax,
    input  gpr_t  ecx,
    input  gpr_t  edx,
    input  gpr_t  ebx,
    input  gpr_t  esp,
    input  gpr_t  ebp,
    input  gpr_t  esi,
    input  gpr_t  edi,
    output gpr_t  reg_0,
    output gpr_t  reg_1,
    output gpr_t  reg_2,
    output gpr_t  reg_3,
    output gpr_t  reg_4,
    output gpr_t  reg_5,
    output gpr_t  reg_6,
    output gpr_t  reg_7
);

    always_comb begin
        reg_0 = '0;
        reg_1 = '0;
        reg_2 = '0;
        reg_3 = '0;
        reg_4 = '0;
        reg_5 = '0;
        reg_6 = '0;
        reg_7 = '0;
        case (size)
            SIZE_8: begin
                // al, cl, dl, bl
                reg_0 = {24'd0, eax[7:0]};
                reg_1 = {24'd0, ecx[7:0]};
                reg_2 = {24'd0, edx[7:0]};
                reg_3 = {24'd0, ebx[7:0]};
                // ah, ch, dh, bh sit where sp..di would be
                reg_4 = {24'd0, eax[15:8]};
                reg_5 = {24'd0, ecx[15:8]};
                reg_6 = {24'd0, edx[15:8]};
                reg_7 = {24'd0, ebx[15:8]};
            end
            SIZE_16: begin
                reg_0 = {16'd0, eax[15:0]};
                reg_1 = {16'd0, ecx[15:0]};
                reg_2 = {16'd0, edx[15:0]};
                reg_3 = {16'd0, ebx[15:0]};
                reg_4 = {16'd0, esp[15:0]};
                reg_5 = {16'd0, ebp[15:0]};
                reg_6 = {16'd0, esi[15:0]};
                reg_7 = {16'd0, edi[15:0]};
            end
            SIZE_32: begin
                reg_0 = eax;
                reg_1 = ecx;
                reg_2 = edx;
                reg_3 = ebx;
                reg_4 = esp;
                reg_5 = ebp;
                reg_6 = esi;
                reg_7 = edi;
            end
            default: ;
        endcase
    end

endmodule

/* verilog/agen_pkg.sv */
// --------------------
// widths are fixed by the x86 register set and cannot be changed
// operand kinds 3 and 4 and size codes above 3 have no function here
// --------------------
package agen_pkg;

    localparam int GPR_W     = 32;
    localparam int SEG_W     = 16;
    localparam int OPERAND_W = 64;
    localparam int ADDR_W    = 32;
    localparam int IMM_W     = 48;
    localparam int CODE_W    = 3;

    typedef logic [GPR_W-1:0]     gpr_t;
    typedef logic [SEG_W-1:0]     seg_t;
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [ADDR_W-1:0]    lin_addr_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [CODE_W-1:0]    size_t;
    typedef logic [CODE_W-1:0]    op_kind_t;
    typedef logic [CODE_W-1:0]    reg_idx_t;
    typedef logic [CODE_W-1:0]    seg_idx_t;

    // operand kinds from decode
    localparam op_kind_t KIND_NONE = 3'd0;
    localparam op_kind_t KIND_REG  = 3'd1;
    localparam op_kind_t KIND_SEG  = 3'd2;
    localparam op_kind_t KIND_IMM  = 3'd5;
    localparam op_kind_t KIND_MEM  = 3'd6;
    localparam op_kind_t KIND_SYS  = 3'd7;

    localparam size_t SIZE_8  = 3'd1;
    localparam size_t SIZE_16 = 3'd2;
    localparam size_t SIZE_32 = 3'd3;

    // segment register numbering as in the modrm reg field
    localparam seg_idx_t SEG_ES = 3'd0;
    localparam seg_idx_t SEG_CS = 3'd1;
    localparam seg_idx_t SEG_SS = 3'd2;
    localparam seg_idx_t SEG_DS = 3'd3;
    localparam seg_idx_t SEG_FS = 3'd4;
    localparam seg_idx_t SEG_GS = 3'd5;

    // real mode style base, selector times 16
    localparam int SEG_SHIFT = 4;

    // segment selector by index, 6 and 7 read as zero
    function automatic seg_t seg_pick(
        input seg_idx_t idx,
        input seg_t     es,
        input seg_t     cs,
        input seg_t     ss,
        input seg_t     ds,
        input seg_t     fs,
        input seg_t     gs
    );
        case (idx)
            SEG_ES:  return es;
            SEG_CS:  return cs;
            SEG_SS:  return ss;
            SEG_DS:  return ds;
            SEG_FS:  return fs;
            SEG_GS:  return gs;
            default: return '0;
        endcase
    endfunction

endpackage
